/* verilog/auto_load_defs.svh */
`ifndef AUTO_LOAD_DEFS_SVH
`define AUTO_LOAD_DEFS_SVH

////////////////////////////////////////
// Parameter bank walk
////////////////////////////////////////

// Last word index inside one parameter block
`define AL_MAX_WORD 6'd33

// Last main block
`define AL_MAX_BLK 3'd7

// Last parameter block
`define AL_MAX_PBLK 2'd3

// Parameter block left out of the walk
`define AL_SKIP_PBLK 2'd2

// Upper address bits of the parameter bank at 0x780000
`define AL_BASE_HI 4'hF

////////////////////////////////////////
// Buffering and constant storage
////////////////////////////////////////

`define AL_FIFO_DEPTH 4

// 8 blocks x 3 parameter blocks x 34 words
`define AL_NUM_CONST 10'd816

`endif

/* verilog/auto_load_pkg.sv */
package auto_load_pkg;

	////////////////////////////////////////
	// Flash side
	////////////////////////////////////////

	// Word address on the BPI flash
	typedef logic [22:0] flash_addr_t;

	// One flash word, also one stored constant
	typedef logic [15:0] flash_word_t;

	// Address pieces walked by the sequencer
	typedef logic [5:0] word_cnt_t;
	typedef logic [2:0] blk_t;
	typedef logic [1:0] pblk_t;

	////////////////////////////////////////
	// Status and storage
	////////////////////////////////////////

	// Bit 2 aborted, bit 1 flash done seen, bit 0 completed
	typedef logic [2:0] al_status_t;

	// Index into the constant bank
	typedef logic [9:0] const_idx_t;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		CLEAR     = 3'd1,
		ISSUE     = 3'd2,
		WAIT_DATA = 3'd3,
		NEXT      = 3'd4,
		FINISH    = 3'd5
	} al_state_t;

endpackage

/* verilog/auto_load_seq.sv */
`include "auto_load_defs.svh"

module auto_load_seq (
	input  logic                      CLK,
	input  logic                      RST,
	input  logic                      start,
	input  logic                      auto_load,
	input  logic                      busy,
	input  logic                      bpi_load_data,
	input  logic                      fifo_full,
	output logic                      execute,
	output logic                      clr,
	output logic                      ena,
	output logic                      aborted,
	output logic                      completed,
	output auto_load_pkg::blk_t       blk,
	output auto_load_pkg::pblk_t      pblk,
	output auto_load_pkg::word_cnt_t  cnt
);

	auto_load_pkg::al_state_t state;
	auto_load_pkg::al_state_t state_nxt;

	logic                 boot;
	logic                 run_req;
	logic                 abort_req;
	logic                 last_word;
	auto_load_pkg::pblk_t pblk_inc;
	auto_load_pkg::pblk_t pblk_step;

	// Kick off once right after reset, or on request
	assign run_req = (start | boot) & auto_load;

	// FINISH is already on its way out, no abort there
	assign abort_req = !auto_load && (state != auto_load_pkg::IDLE)
		&& (state != auto_load_pkg::FINISH);

	assign last_word = (cnt == `AL_MAX_WORD) && (pblk == `AL_MAX_PBLK)
		&& (blk == `AL_MAX_BLK);

	// Next parameter block, hopping over the skipped one
	assign pblk_inc  = pblk + 2'd1;
	assign pblk_step = (pblk_inc == `AL_SKIP_PBLK) ? pblk_inc + 2'd1 : pblk_inc;

	// Outputs decoded from state
	assign clr       = (state == auto_load_pkg::CLEAR);
	assign ena       = (state != auto_load_pkg::IDLE);
	assign completed = (state == auto_load_pkg::FINISH);
	assign aborted   = abort_req;
	assign execute   = (state == auto_load_pkg::ISSUE) && auto_load && !busy && !fifo_full;

	always_comb begin
		state_nxt = state;
		case (state)
			auto_load_pkg::IDLE:      if (run_req) state_nxt = auto_load_pkg::CLEAR;
			auto_load_pkg::CLEAR:     state_nxt = auto_load_pkg::ISSUE;
			auto_load_pkg::ISSUE:     if (execute) state_nxt = auto_load_pkg::WAIT_DATA;
			auto_load_pkg::WAIT_DATA: if (bpi_load_data) state_nxt = auto_load_pkg::NEXT;
			auto_load_pkg::NEXT: begin
				if (last_word)
					state_nxt = auto_load_pkg::FINISH;
				else
					state_nxt = auto_load_pkg::ISSUE;
			end
			auto_load_pkg::FINISH:    state_nxt = auto_load_pkg::IDLE;
			default:                  state_nxt = auto_load_pkg::IDLE;
		endcase
		// Loss of auto_load ends the run from any active state
		if (abort_req)
			state_nxt = auto_load_pkg::IDLE;
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= auto_load_pkg::IDLE;
			boot  <= 1'b1;
		end else begin
			state <= state_nxt;
			boot  <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Address counters
	////////////////////////////////////////

	// Word first, then parameter block, then main block
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cnt  <= '0;
			pblk <= '0;
			blk  <= '0;
		end else if (state == auto_load_pkg::CLEAR) begin
			cnt  <= '0;
			pblk <= '0;
			blk  <= '0;
		end else if (state == auto_load_pkg::NEXT && !last_word && !abort_req) begin
			if (cnt != `AL_MAX_WORD) begin
				cnt <= cnt + 6'd1;
			end else begin
				cnt <= '0;
				if (pblk == `AL_MAX_PBLK) begin
					pblk <= '0;
					blk  <= blk + 3'd1;
				end else begin
					pblk <= pblk_step;
				end
			end
		end
	end

endmodule

/* verilog/auto_load_ctrl.sv */
`include "auto_load_defs.svh"

module auto_load_ctrl (
	input  logic                        CLK,
	input  logic                        RST,
	input  logic                        al_start,
	input  logic                        auto_load,
	input  logic                        busy,
	input  logic                        bpi_load_data,
	input  logic                        al_done,
	input  logic                        fifo_full,
	output auto_load_pkg::flash_addr_t  al_addr,
	output logic                        al_execute,
	output logic                        auto_load_ena,
	output logic                        clr_al_done,
	output auto_load_pkg::al_status_t   al_status
);

	auto_load_pkg::blk_t      al_blk;
	auto_load_pkg::pblk_t     al_pblk;
	auto_load_pkg::word_cnt_t al_cnt;
	logic                     al_aborted;
	logic                     al_completed;

	auto_load_seq seq_i (
		.CLK           (CLK),
		.RST           (RST),
		.start         (al_start),
		.auto_load     (auto_load),
		.busy          (busy),
		.bpi_load_data (bpi_load_data),
		.fifo_full     (fifo_full),
		.execute       (al_execute),
		.clr           (clr_al_done),
		.ena           (auto_load_ena),
		.aborted       (al_aborted),
		.completed     (al_completed),
		.blk           (al_blk),
		.pblk          (al_pblk),
		.cnt           (al_cnt)
	);

	// Parameter bank address, rows of 64 words per parameter block slot
	assign al_addr = {`AL_BASE_HI, al_blk, al_pblk, 8'b0000_0000, al_cnt};

	////////////////////////////////////////
	// Sticky status
	////////////////////////////////////////

	// Clear wins, then abort, then flash done, then completion
	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			al_status <= '0;
		else if (clr_al_done)
			al_status <= '0;
		else if (al_aborted)
			al_status <= {1'b1, al_status[1:0]};
		else if (al_done)
			al_status <= {al_status[2], 1'b1, al_status[0]};
		else if (al_completed)
			al_status <= {al_status[2:1], 1'b1};
	end

endmodule

/* verilog/const_fifo.sv */
`include "auto_load_defs.svh"

module const_fifo #(
	parameter int DEPTH = `AL_FIFO_DEPTH
) (
	input  logic                        CLK,
	input  logic                        RST,
	input  logic                        clr,
	input  logic                        wr,
	input  auto_load_pkg::flash_word_t  wr_data,
	input  logic                        rd,
	output auto_load_pkg::flash_word_t  rd_data,
	output logic                        empty,
	output logic                        full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	auto_load_pkg::flash_word_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_wr;
	logic          do_rd;

	assign empty = (count == 0);
	assign full  = (count == DEPTH);

	// Overflow and underflow are simply refused
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	// Head word is visible the cycle after it lands
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (do_wr && !clr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

/* verilog/const_loader.sv */
`include "auto_load_defs.svh"

module const_loader (
	input  logic                        CLK,
	input  logic                        RST,
	input  logic                        clr,
	input  logic                        fifo_empty,
	input  auto_load_pkg::flash_word_t  fifo_data,
	output logic                        pop,
	input  auto_load_pkg::const_idx_t   rd_sel,
	output auto_load_pkg::flash_word_t  rd_data,
	output logic                        load_full
);

	auto_load_pkg::flash_word_t bank [`AL_NUM_CONST];

	auto_load_pkg::const_idx_t idx;
	logic                      wr_en;

	// Drain one word per cycle
	assign pop = !fifo_empty;

	// Table is complete once every slot has been written
	assign load_full = (idx == `AL_NUM_CONST);

	assign wr_en = pop && !load_full && !clr;

	////////////////////////////////////////
	// Write index
	////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			idx <= '0;
		else if (clr)
			idx <= '0;
		else if (wr_en)
			idx <= idx + 10'd1;
	end

	////////////////////////////////////////
	// Constant bank
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (wr_en)
			bank[idx] <= fifo_data;
		// Registered read port for the rest of the chip
		rd_data <= bank[rd_sel];
	end

endmodule

/* verilog/auto_load_top.sv */
`include "auto_load_defs.svh"

module auto_load_top (
	input  logic                        CLK,
	input  logic                        RST,
	input  logic                        auto_load,
	input  logic                        al_start,
	input  logic                        busy,
	input  logic                        bpi_load_data,
	input  auto_load_pkg::flash_word_t  bpi_al_reg,
	input  logic                        al_done,
	input  auto_load_pkg::const_idx_t   rd_sel,
	output auto_load_pkg::flash_addr_t  al_addr,
	output logic                        al_execute,
	output logic                        auto_load_ena,
	output logic                        clr_al_done,
	output auto_load_pkg::al_status_t   al_status,
	output auto_load_pkg::flash_word_t  rd_data,
	output logic                        load_full
);

	logic                       fifo_wr;
	logic                       fifo_pop;
	logic                       fifo_empty;
	logic                       fifo_full;
	auto_load_pkg::flash_word_t fifo_data;

	// Late data after an abort never reaches the buffer
	assign fifo_wr = bpi_load_data & auto_load_ena;

	auto_load_ctrl ctrl_i (
		.CLK           (CLK),
		.RST           (RST),
		.al_start      (al_start),
		.auto_load     (auto_load),
		.busy          (busy),
		.bpi_load_data (bpi_load_data),
		.al_done       (al_done),
		.fifo_full     (fifo_full),
		.al_addr       (al_addr),
		.al_execute    (al_execute),
		.auto_load_ena (auto_load_ena),
		.clr_al_done   (clr_al_done),
		.al_status     (al_status)
	);

	const_fifo #(
		.DEPTH (`AL_FIFO_DEPTH)
	) fifo_i (
		.CLK     (CLK),
		.RST     (RST),
		.clr     (clr_al_done),
		.wr      (fifo_wr),
		.wr_data (bpi_al_reg),
		.rd      (fifo_pop),
		.rd_data (fifo_data),
		.empty   (fifo_empty),
		.full    (fifo_full)
	);

	const_loader loader_i (
		.CLK        (CLK),
		.RST        (RST),
		.clr        (clr_al_done),
		.fifo_empty (fifo_empty),
		.fifo_data  (fifo_data),
		.pop        (fifo_pop),
		.rd_sel     (rd_sel),
		.rd_data    (rd_data),
		.load_full  (load_full)
	);

endmodule

/* tb/auto_load_asserts.sv */
module auto_load_asserts (
	input logic CLK,
	input logic RST,
	input logic busy,
	input logic al_execute,
	input logic fifo_wr,
	input logic fifo_full,
	input logic clr_al_done
);

	// Count of failed assertions
	int fails = 0;

	// Flash must be idle before a new read
	exec_idle: assert property (@(posedge CLK) disable iff (RST) al_execute |-> !busy)
		else begin
			fails++;
			$error("al_execute raised while busy is high");
		end

	fifo_room: assert property (@(posedge CLK) disable iff (RST) fifo_wr |-> !fifo_full)
		else begin
			fails++;
			$error("FIFO write while full");
		end

	// Clear is a single-cycle pulse
	clr_pulse: assert property (@(posedge CLK) disable iff (RST) clr_al_done |=> !clr_al_done)
		else begin
			fails++;
			$error("clr_al_done longer than one cycle");
		end

endmodule

bind auto_load_top auto_load_asserts asserts_i (
	.CLK         (CLK),
	.RST         (RST),
	.busy        (busy),
	.al_execute  (al_execute),
	.fifo_wr     (fifo_wr),
	.fifo_full   (fifo_full),
	.clr_al_done (clr_al_done)
);

/* tb/auto_load_tb.sv */
`include "auto_load_defs.svh"

module auto_load_tb;

	localparam int NUM  = `AL_NUM_CONST;
	localparam int RUNS = 5;

	logic                       CLK;
	logic                       RST;
	logic                       auto_load;
	logic                       al_start;
	logic                       busy;
	logic                       bpi_load_data;
	auto_load_pkg::flash_word_t bpi_al_reg;
	logic                       al_done;
	auto_load_pkg::const_idx_t  rd_sel;
	auto_load_pkg::flash_addr_t al_addr;
	logic                       al_execute;
	logic                       auto_load_ena;
	logic                       clr_al_done;
	auto_load_pkg::al_status_t  al_status;
	auto_load_pkg::flash_word_t rd_data;
	logic                       load_full;

	logic [31:0] rng = 32'h4ebf;
	int          exec_idx;
	int          exec_total;
	int          extra_busy_max;
	int          errors;
	int          mark;
	int          tests_run;
	int          tests_failed;
	int          total;
	int          frozen;
	string       cur_test;

	auto_load_top dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// 34 words per parameter block, parameter blocks 0, 1 and 3 per main block
	function automatic auto_load_pkg::flash_addr_t model_addr(input int i);
		logic [1:0] pb;
		pb = ((i / 34) % 3 == 2) ? 2'd3 : 2'((i / 34) % 3);
		return {4'hF, 3'(i / 102), pb, 8'h00, 6'(i % 34)};
	endfunction

	// Flash contents as seen by the model
	function automatic auto_load_pkg::flash_word_t word_hash(input auto_load_pkg::flash_addr_t a);
		logic [31:0] x;
		x = {9'd0, a} * 32'h0000_9e37;
		return x[31:16] ^ x[15:0];
	endfunction

	task automatic check_word(input string what, input auto_load_pkg::flash_word_t exp,
		input auto_load_pkg::flash_word_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_addr(input auto_load_pkg::flash_addr_t exp,
		input auto_load_pkg::flash_addr_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s al_addr[%0d] expected %h actual %h", cur_test, exec_idx, exp, act);
		end
	endtask

	task automatic check_status(input auto_load_pkg::al_status_t exp,
		input auto_load_pkg::al_status_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s al_status expected %b actual %b", cur_test, exp, act);
		end
	endtask

	task automatic verify_read_count();
		if (exec_idx != NUM) begin
			errors++;
			$display("ERR %s read count expected %0d actual %0d", cur_test, NUM, exec_idx);
		end
	endtask

	task automatic flag_fault(input string msg);
		errors++;
		$display("%s: %s", cur_test, msg);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		mark = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == mark) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed", cur_test);
		end
	endtask

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Request a run and see the status cleared by clr_al_done
	task automatic start_run();
		al_start <= 1'b1;
		@(posedge CLK);
		al_start <= 1'b0;
		while (!clr_al_done)
			@(posedge CLK);
		@(posedge CLK);
		check_status(3'b000, al_status);
		if (load_full)
			flag_fault("load_full still high after clr_al_done");
	endtask

	task automatic wait_execs(input int n);
		while (exec_idx < n)
			@(posedge CLK);
	endtask

	task automatic wait_run_end();
		while (!(load_full && !auto_load_ena))
			@(posedge CLK);
	endtask

	// Pipelined read back, rd_data trails rd_sel by two sampling edges
	task automatic read_back();
		for (int i = 0; i < NUM + 2; i++) begin
			@(posedge CLK);
			if (i < NUM)
				rd_sel <= auto_load_pkg::const_idx_t'(i);
			if (i >= 2)
				check_word($sformatf("rd_data[%0d]", i - 2), word_hash(model_addr(i - 2)), rd_data);
		end
	endtask

	// Flash model, one read in flight, busy held until the word is back
	initial begin : flash_model
		auto_load_pkg::flash_addr_t addr;
		int                         delay;
		int                         extra;
		forever begin
			@(posedge CLK);
			if (!RST && clr_al_done)
				exec_idx = 0;
			if (!RST && al_execute) begin
				addr = al_addr;
				check_addr(model_addr(exec_idx), addr);
				exec_idx++;
				exec_total++;
				busy <= 1'b1;
				rng = xorshift32(rng);
				delay = 1 + int'(rng % 6);
				rng = xorshift32(rng);
				extra = (extra_busy_max > 0) ? int'(rng % (extra_busy_max + 1)) : 0;
				repeat (delay) @(posedge CLK);
				bpi_load_data <= 1'b1;
				bpi_al_reg    <= word_hash(addr);
				busy          <= (extra > 0);
				@(posedge CLK);
				bpi_load_data <= 1'b0;
				if (extra > 0) begin
					repeat (extra) @(posedge CLK);
					busy <= 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (RUNS * NUM * 20) @(posedge CLK);
		$display("Watchdog expired before all tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : main
		RST           = 1'b1;
		auto_load     = 1'b1;
		al_start      = 1'b0;
		busy          = 1'b0;
		bpi_load_data = 1'b0;
		bpi_al_reg    = '0;
		al_done       = 1'b0;
		rd_sel        = '0;
		repeat (5) @(posedge CLK);
		RST <= 1'b0;

		// Run started by reset alone
		begin_test("boot_walk");
		wait_run_end();
		verify_read_count();
		end_test();

		begin_test("contents");
		read_back();
		end_test();

		begin_test("completion");
		check_status(3'b001, al_status);
		if (auto_load_ena)
			flag_fault("auto_load_ena still high after the run");
		end_test();

		begin_test("flash_done");
		start_run();
		wait_execs(200);
		al_done <= 1'b1;
		@(posedge CLK);
		al_done <= 1'b0;
		wait_run_end();
		verify_read_count();
		check_status(3'b011, al_status);
		end_test();

		begin_test("abort");
		start_run();
		wait_execs(300);
		auto_load <= 1'b0;
		repeat (2) @(posedge CLK);
		frozen = exec_total;
		repeat (40) @(posedge CLK);
		if (exec_total != frozen)
			flag_fault("flash reads issued after auto_load dropped");
		if (load_full || auto_load_ena)
			flag_fault("load_full or auto_load_ena high after abort");
		check_status(3'b100, al_status);
		end_test();

		begin_test("restart");
		auto_load <= 1'b1;
		@(posedge CLK);
		start_run();
		wait_run_end();
		verify_read_count();
		check_status(3'b001, al_status);
		read_back();
		end_test();

		// Longer busy tails after each word
		begin_test("backpressure");
		extra_busy_max = 4;
		start_run();
		wait_run_end();
		verify_read_count();
		read_back();
		end_test();

		total = errors + dut_i.asserts_i.fails;
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
		if (total == 0 && tests_failed == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* auto_load.f */
+incdir+verilog
verilog/auto_load_pkg.sv
verilog/auto_load_seq.sv
verilog/auto_load_ctrl.sv
verilog/const_fifo.sv
verilog/const_loader.sv
verilog/auto_load_top.sv
tb/auto_load_asserts.sv
tb/auto_load_tb.sv

/* Bender.yml */
package:
  name: auto_load

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/auto_load_pkg.sv
      - verilog/auto_load_seq.sv
      - verilog/auto_load_ctrl.sv
      - verilog/const_fifo.sv
      - verilog/const_loader.sv
      - verilog/auto_load_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/auto_load_asserts.sv
      - tb/auto_load_tb.sv
